// File: ec_point_add_top.f
+incdir+verification
source/ec_pkg.sv
source/field_mult.sv
source/point_add.sv
source/ec_point_add_top.sv
verification/tb_ec_point_add.sv

// File: Makefile
# Verilator flow for the EC point adder
TOP := tb_ec_point_add
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for a pass"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f ec_point_add_top.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/tb_ec_model.svh
`ifndef TB_EC_MODEL_SVH
`define TB_EC_MODEL_SVH

// Reference GF(p) arithmetic for the testbench
// Full 512-bit product, then one remainder by P
function automatic ec_pkg::field_t fmul(input ec_pkg::field_t a, input ec_pkg::field_t b);
  logic [511:0] prod;
  prod = {256'd0, a} * {256'd0, b};
  prod = prod % {256'd0, ec_pkg::P};
  return prod[255:0];
endfunction

function automatic ec_pkg::field_t fadd(input ec_pkg::field_t a, input ec_pkg::field_t b);
  logic [256:0] s;
  s = {1'b0, a} + {1'b0, b}; // Below 2P for reduced inputs
  if (s >= {1'b0, ec_pkg::P}) s = s - {1'b0, ec_pkg::P};
  return s[255:0];
endfunction

// a + (P - b), b == 0 gives a + P which fadd folds back
function automatic ec_pkg::field_t fsub(input ec_pkg::field_t a, input ec_pkg::field_t b);
  return fadd(a, ec_pkg::P - b);
endfunction

// Textbook Jacobian addition, no special cases
function automatic ec_pkg::jb_point_t jacobian_add(input ec_pkg::jb_point_t p,
                                                   input ec_pkg::jb_point_t q);
  ec_pkg::field_t    z1s, z2s, u1, u2, s1, s2, h, r, h2, h3, v;
  ec_pkg::jb_point_t res;
  z1s   = fmul(p.z, p.z);
  z2s   = fmul(q.z, q.z);
  u1    = fmul(p.x, z2s);
  u2    = fmul(q.x, z1s);
  s1    = fmul(p.y, fmul(z2s, q.z));
  s2    = fmul(q.y, fmul(z1s, p.z));
  h     = fsub(u2, u1);
  r     = fsub(s2, s1);
  h2    = fmul(h, h);
  h3    = fmul(h2, h);
  v     = fmul(u1, h2);                          // U1*H^2
  res.x = fsub(fsub(fmul(r, r), h3), fadd(v, v));
  res.y = fsub(fmul(r, fsub(v, res.x)), fmul(s1, h3));
  res.z = fmul(fmul(p.z, q.z), h);
  return res;
endfunction

`endif

// File: verification/tb_ec_point_add.sv
`default_nettype none

module tb_ec_point_add;

  localparam int N_TESTS = 6;
  localparam int TIMEOUT = N_TESTS * 30 * (ec_pkg::MULT_CYCLES + 10) * 40;

  logic              i_clk = 1'b0;
  logic              i_rst;
  ec_pkg::jb_point_t i_p1, i_p2;
  logic              i_val;
  logic              o_rdy;
  ec_pkg::jb_point_t o_p;
  logic              o_val;
  logic              o_err;
  logic              i_rdy;
  integer            seed;
  int                n_checks = 0;
  int                n_errors = 0;

  `include "tb_ec_model.svh"

  always #20 i_clk = ~i_clk; // 40 unit period

  ec_point_add_top dut0 (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_p1  (i_p1),
    .i_p2  (i_p2),
    .i_val (i_val),
    .o_rdy (o_rdy),
    .o_p   (o_p),
    .o_val (o_val),
    .o_err (o_err),
    .i_rdy (i_rdy)
  );

  task automatic check_point(input ec_pkg::jb_point_t got, input ec_pkg::jb_point_t want,
                             input string what);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("Fail at %0t: %s", $time, what);
      if (got.x !== want.x) $display("  x got %h expected %h", got.x, want.x);
      if (got.y !== want.y) $display("  y got %h expected %h", got.y, want.y);
      if (got.z !== want.z) $display("  z got %h expected %h", got.z, want.z);
    end
  endtask

  // Single status bit such as o_err
  task automatic check_err(input logic got, input logic want, input string what);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("Fail at %0t: %s got %b expected %b", $time, what, got, want);
    end
  endtask

  // Eight draws and one subtract to stay below P
  function automatic ec_pkg::field_t rand_field();
    ec_pkg::field_t v;
    v = {$random(seed), $random(seed), $random(seed), $random(seed),
         $random(seed), $random(seed), $random(seed), $random(seed)};
    if (v >= ec_pkg::P) v = v - ec_pkg::P;
    return v;
  endfunction

  function automatic ec_pkg::field_t rand_nonzero();
    ec_pkg::field_t v;
    do v = rand_field(); while (v == '0);
    return v;
  endfunction

  function automatic ec_pkg::jb_point_t rand_point(input logic unit_z);
    ec_pkg::jb_point_t p;
    p.x = rand_field();
    p.y = rand_field();
    p.z = unit_z ? ec_pkg::field_t'(1) : rand_nonzero(); // z = 1 is affine
    return p;
  endfunction

  task automatic apply_reset();
    @(posedge i_clk);
    i_rst <= 1'b1;
    i_val <= 1'b0;
    repeat (10) @(posedge i_clk);
    i_rst <= 1'b0;
  endtask

  // Present the pair and drop i_val on the accepting edge
  task automatic send_pair(input ec_pkg::jb_point_t a, input ec_pkg::jb_point_t b);
    @(posedge i_clk);
    i_p1  <= a;
    i_p2  <= b;
    i_val <= 1'b1;
    do @(negedge i_clk); while (!o_rdy);
    @(posedge i_clk); // Transfer
    i_val <= 1'b0;
  endtask

  // Result sampled at negedge
  task automatic wait_result(output ec_pkg::jb_point_t p, output logic err);
    do @(negedge i_clk); while (!o_val);
    p   = o_p;
    err = o_err;
  endtask

  task automatic general_addition();
    ec_pkg::jb_point_t a, b, got;
    logic              err;
    int                i;
    for (i = 0; i < 4; i++) begin
      a = rand_point(i < 2); // First two with z = 1
      b = rand_point(i < 2);
      while (b.x == a.x) b.x = rand_field();
      send_pair(a, b);
      wait_result(got, err);
      check_point(got, jacobian_add(a, b), $sformatf("general addition %0d result", i));
      check_err(err, 1'b0, $sformatf("general addition %0d o_err", i));
    end
  endtask

  task automatic infinity_input();
    ec_pkg::jb_point_t a, b, got;
    logic              err;
    a   = rand_point(1'b0);
    b   = rand_point(1'b0);
    a.z = '0;
    send_pair(a, b);
    wait_result(got, err);
    check_point(got, b, "p1 at infinity");
    check_err(err, 1'b0, "p1 at infinity o_err");
    a.z = rand_nonzero();
    b.z = '0;
    send_pair(a, b);
    wait_result(got, err);
    check_point(got, a, "p2 at infinity");
    check_err(err, 1'b0, "p2 at infinity o_err");
  endtask

  task automatic opposite_points();
    ec_pkg::jb_point_t a, b, got;
    logic              err;
    a   = rand_point(1'b0);
    b   = rand_point(1'b0);
    b.x = a.x;
    while (b.y == a.y) b.y = rand_field();
    send_pair(a, b);
    wait_result(got, err);
    check_point(got, '0, "opposite points give infinity");
    check_err(err, 1'b0, "opposite points o_err");
  endtask

  task automatic same_point_error();
    ec_pkg::jb_point_t a, got;
    logic              err;
    a = rand_point(1'b0);
    send_pair(a, a);
    wait_result(got, err);
    check_err(err, 1'b1, "same point o_err");
  endtask

  task automatic back_pressure();
    ec_pkg::jb_point_t a, b, got, want;
    logic              err;
    logic [31:0]       r;
    int                hold;
    a    = rand_point(1'b0);
    b    = rand_point(1'b0);
    want = jacobian_add(a, b);
    r    = $random(seed);
    hold = int'(r[3:0]) + 1; // 1 to 16 stalled cycles
    @(posedge i_clk);
    i_rdy <= 1'b0;
    send_pair(a, b);
    wait_result(got, err);
    check_point(got, want, "stalled addition result");
    check_err(err, 1'b0, "stalled addition o_err");
    repeat (hold) begin
      @(negedge i_clk);
      check_point(o_p, want, "o_p moved under back-pressure");
      check_err(o_val, 1'b1, "o_val under back-pressure");
      check_err(o_rdy, 1'b0, "o_rdy before the transfer");
    end
    @(posedge i_clk);
    i_rdy <= 1'b1;
    @(negedge i_clk);
    check_err(o_rdy, 1'b0, "o_rdy before the transfer");
    a = rand_point(1'b0);   // Second pair follows at once
    b = rand_point(1'b0);
    send_pair(a, b);
    wait_result(got, err);
    check_point(got, jacobian_add(a, b), "back-to-back addition result");
    check_err(err, 1'b0, "back-to-back addition o_err");
  endtask

  // Reset lands while a flagged result is still held
  task automatic reset_state();
    ec_pkg::jb_point_t a, got;
    logic              err;
    int                n;
    a = rand_point(1'b0);
    @(posedge i_clk);
    i_rdy <= 1'b0;
    send_pair(a, a);
    wait_result(got, err);
    check_err(err, 1'b1, "held result o_err before reset");
    apply_reset();
    i_rdy <= 1'b1;
    @(negedge i_clk);
    check_err(o_val, 1'b0, "o_val after reset");
    check_err(o_err, 1'b0, "o_err after reset");
    n = 1;
    while (!o_rdy && n < 2) begin
      @(negedge i_clk);
      n++;
    end
    check_err(o_rdy, 1'b1, "o_rdy within two cycles of reset");
  endtask

  initial begin : watchdog
    #(TIMEOUT);
    $display("Watchdog expired, the DUT stopped answering");
    $display("Regression failed");
    $finish;
  end

  initial begin : main
    seed = 32'hc8429010;
    i_rst <= 1'b1;
    i_val <= 1'b0;
    i_rdy <= 1'b1;
    i_p1  <= '0;
    i_p2  <= '0;
    apply_reset();
    general_addition();
    infinity_input();
    opposite_points();
    same_point_error();
    back_pressure();
    reset_state();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/ec_point_add_top.sv
`default_nettype none

// Point adder sharing one field multiplier
module ec_point_add_top (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  input  wire ec_pkg::jb_point_t i_p1,
  input  wire ec_pkg::jb_point_t i_p2,
  input  wire logic              i_val,
  output logic                   o_rdy,
  output ec_pkg::jb_point_t      o_p,
  output logic                   o_val,
  output logic                   o_err,
  input  wire logic              i_rdy
);

  ec_pkg::mult_req_t mul_req;  // Adder to multiplier
  logic              mul_val;
  logic              mul_rdy;
  ec_pkg::mult_rsp_t mul_rsp;  // Product back, tagged by step
  logic              rsp_val;
  logic              rsp_rdy;

  point_add u_add (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_p1      (i_p1),
    .i_p2      (i_p2),
    .i_val     (i_val),
    .o_rdy     (o_rdy),
    .o_p       (o_p),
    .o_val     (o_val),
    .o_err     (o_err),
    .i_rdy     (i_rdy),
    .o_mul_req (mul_req),
    .o_mul_val (mul_val),
    .i_mul_rdy (mul_rdy),
    .i_rsp     (mul_rsp),
    .i_rsp_val (rsp_val),
    .o_rsp_rdy (rsp_rdy)
  );

  field_mult u_mult (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req     (mul_req),
    .i_req_val (mul_val),
    .o_req_rdy (mul_rdy),
    .o_rsp     (mul_rsp),
    .o_rsp_val (rsp_val),
    .i_rsp_rdy (rsp_rdy)
  );

endmodule

`default_nettype wire

// File: source/point_add.sv
`default_nettype none

module point_add (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  input  wire ec_pkg::jb_point_t i_p1,
  input  wire ec_pkg::jb_point_t i_p2,
  input  wire logic              i_val,
  output logic                   o_rdy,      // Idle only
  output ec_pkg::jb_point_t      o_p,
  output logic                   o_val,
  output logic                   o_err,      // Same point or stray tag
  input  wire logic              i_rdy,
  output ec_pkg::mult_req_t      o_mul_req,
  output logic                   o_mul_val,
  input  wire logic              i_mul_rdy,
  input  wire ec_pkg::mult_rsp_t i_rsp,
  input  wire logic              i_rsp_val,
  output logic                   o_rsp_rdy
);

  // Step schedule where [n] means step n must be done
  // Latched inputs are reused as temps
  //  0 A = Z2^2            1 X1 = A*X1 [0] U1     2 C = Z1^2
  //  3 X2 = C*X2 [2] U2    4 A = A*Z2 [1]         5 A = A*Y1 [4] S1
  //  6 C = C*Z1 [3]        7 C = C*Y2 [6] S2      8 B = X2 - X1 [1,3] H
  //  9 Y2 = C - A [5,7] R  10 OX = Y2^2 [9]       11 D = B^2 [8]
  // 12 X2 = D*B [8,11]     13 OX = OX - X2 [10,12]
  // 14 X1 = X1*D [1,11]    15 OY = X1 [14]        16 X1 = 2*X1 [14,15]
  // 17 OX = OX - X1 [13,16] X3                    18 OY = OY - OX [15,17]
  // 19 OY = OY*Y2 [9,18]   20 X2 = X2*A [5,12,13] 21 OY = OY - X2 [19,20] Y3
  // 22 OZ = Z1*Z2          23 OZ = OZ*B [8,22] Z3

  typedef enum logic [1:0] {S_IDLE, S_CALC, S_DONE} state_t;

  state_t            state;
  logic [23:0]       eq_val;    // Step result written
  logic [23:0]       eq_wait;   // Step started
  logic [23:0]       loc_go;    // In-module steps firing now
  logic [23:0]       iss_mask;
  logic [23:0]       rsp_mask;
  ec_pkg::field_t    tmp_a, tmp_b, tmp_c, tmp_d;
  ec_pkg::jb_point_t p1_l, p2_l;
  ec_pkg::mult_req_t iss;       // Highest priority ready multiply
  logic              iss_go;
  logic              in_fire, rsp_fire, mul_free;
  logic              same_x, same_y, at_inf;

  assign in_fire   = i_val && o_rdy;
  assign rsp_fire  = i_rsp_val && o_rsp_rdy;
  assign mul_free  = !o_mul_val || i_mul_rdy;  // Request slot empty or leaving
  assign o_rsp_rdy = (state == S_CALC);

  // Special cases on the raw inputs
  assign same_x = (i_p1.x == i_p2.x);
  assign same_y = (i_p1.y == i_p2.y);
  assign at_inf = (i_p1.z == '0) || (i_p2.z == '0);

  // Fixed priority multiply pick
  always_comb begin
    iss_go = 1'b1;
    iss    = '0;
    if (!eq_wait[0]) begin
      iss = '{a: p2_l.z, b: p2_l.z, tag: 5'd0};
    end else if (eq_val[0] && !eq_wait[1]) begin
      iss = '{a: tmp_a, b: p1_l.x, tag: 5'd1};
    end else if (!eq_wait[2]) begin
      iss = '{a: p1_l.z, b: p1_l.z, tag: 5'd2};
    end else if (eq_val[2] && !eq_wait[3]) begin
      iss = '{a: tmp_c, b: p2_l.x, tag: 5'd3};
    end else if (eq_val[1] && !eq_wait[4]) begin
      iss = '{a: tmp_a, b: p2_l.z, tag: 5'd4};
    end else if (eq_val[4] && !eq_wait[5]) begin
      iss = '{a: tmp_a, b: p1_l.y, tag: 5'd5};
    end else if (eq_val[3] && !eq_wait[6]) begin
      iss = '{a: tmp_c, b: p1_l.z, tag: 5'd6};
    end else if (eq_val[6] && !eq_wait[7]) begin
      iss = '{a: tmp_c, b: p2_l.y, tag: 5'd7};
    end else if (eq_val[9] && !eq_wait[10]) begin
      iss = '{a: p2_l.y, b: p2_l.y, tag: 5'd10}; // R^2
    end else if (eq_val[8] && !eq_wait[11]) begin
      iss = '{a: tmp_b, b: tmp_b, tag: 5'd11};   // H^2
    end else if (eq_val[8] && eq_val[11] && !eq_wait[12]) begin
      iss = '{a: tmp_d, b: tmp_b, tag: 5'd12};   // H^3
    end else if (eq_val[1] && eq_val[11] && !eq_wait[14]) begin
      iss = '{a: tmp_d, b: p1_l.x, tag: 5'd14};  // U1*H^2
    end else if (eq_val[9] && eq_val[18] && !eq_wait[19]) begin
      iss = '{a: o_p.y, b: p2_l.y, tag: 5'd19};
    end else if (eq_val[5] && eq_val[12] && eq_val[13] && !eq_wait[20]) begin
      iss = '{a: p2_l.x, b: tmp_a, tag: 5'd20};  // S1*H^3 once step 13 has read X2
    end else if (!eq_wait[22]) begin
      iss = '{a: p1_l.z, b: p2_l.z, tag: 5'd22};
    end else if (eq_val[8] && eq_val[22] && !eq_wait[23]) begin
      iss = '{a: o_p.z, b: tmp_b, tag: 5'd23};
    end else begin
      iss_go = 1'b0;
    end
  end

  // Subtract, copy and double steps take one cycle each
  always_comb begin
    loc_go     = '0;
    loc_go[8]  = eq_val[1] && eq_val[3] && !eq_wait[8];
    loc_go[9]  = eq_val[5] && eq_val[7] && !eq_wait[9];
    loc_go[13] = eq_val[10] && eq_val[12] && !eq_wait[13];
    loc_go[15] = eq_val[14] && !eq_wait[15];
    loc_go[16] = eq_val[14] && eq_val[15] && !eq_wait[16]; // Copy before the double
    loc_go[17] = eq_val[13] && eq_val[16] && !eq_wait[17];
    loc_go[18] = eq_val[15] && eq_val[17] && !eq_wait[18];
    loc_go[21] = eq_val[19] && eq_val[20] && !eq_wait[21];
    iss_mask   = (iss_go && mul_free) ? (24'd1 << iss.tag) : '0;
    rsp_mask   = rsp_fire ? (24'd1 << i_rsp.tag) : '0;  // Stray tags fall off the top
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= S_IDLE;
      o_rdy     <= 1'b0;
      o_val     <= 1'b0;
      o_err     <= 1'b0;
      o_mul_val <= 1'b0;
      eq_val    <= '0;
      eq_wait   <= '0;
    end else begin
      if (o_mul_val && i_mul_rdy) o_mul_val <= 1'b0;
      case (state)
        S_IDLE: begin
          o_rdy <= 1'b1;
          if (in_fire) begin
            o_rdy   <= 1'b0;
            p1_l    <= i_p1;
            p2_l    <= i_p2;
            eq_val  <= '0;
            eq_wait <= '0;
            state   <= S_CALC;
            if (at_inf) begin
              o_p   <= (i_p1.z == '0) ? i_p2 : i_p1; // Other point
              o_val <= 1'b1;
              state <= S_DONE;
            end else if (same_x && !same_y) begin
              o_p   <= '0;   // Opposite points give infinity
              o_val <= 1'b1;
              state <= S_DONE;
            end else if (same_x) begin
              o_p   <= '0;
              o_err <= 1'b1; // Doubling not handled here
              o_val <= 1'b1;
              state <= S_DONE;
            end
          end
        end
        S_CALC: begin
          eq_val  <= eq_val | loc_go | rsp_mask;
          eq_wait <= eq_wait | loc_go | iss_mask;
          if (rsp_fire) begin
            case (i_rsp.tag)
              5'd0, 5'd4, 5'd5:   tmp_a  <= i_rsp.prod;
              5'd1, 5'd14:        p1_l.x <= i_rsp.prod;
              5'd2, 5'd6, 5'd7:   tmp_c  <= i_rsp.prod;
              5'd3, 5'd12, 5'd20: p2_l.x <= i_rsp.prod;
              5'd10:              o_p.x  <= i_rsp.prod;
              5'd11:              tmp_d  <= i_rsp.prod;
              5'd19:              o_p.y  <= i_rsp.prod;
              5'd22, 5'd23:       o_p.z  <= i_rsp.prod;
              default: begin
                o_err <= 1'b1; // Not a multiply step
                o_val <= 1'b1;
                state <= S_DONE;
              end
            endcase
          end
          if (iss_go && mul_free) begin
            o_mul_req <= iss;
            o_mul_val <= 1'b1;
          end
          if (loc_go[8])  tmp_b  <= ec_pkg::sub_mod(p2_l.x, p1_l.x);  // H
          if (loc_go[9])  p2_l.y <= ec_pkg::sub_mod(tmp_c, tmp_a);    // R
          if (loc_go[13]) o_p.x  <= ec_pkg::sub_mod(o_p.x, p2_l.x);
          if (loc_go[15]) o_p.y  <= p1_l.x;
          if (loc_go[16]) p1_l.x <= ec_pkg::add_mod(p1_l.x, p1_l.x);
          if (loc_go[17]) o_p.x  <= ec_pkg::sub_mod(o_p.x, p1_l.x);
          if (loc_go[18]) o_p.y  <= ec_pkg::sub_mod(o_p.y, o_p.x);
          if (loc_go[21]) o_p.y  <= ec_pkg::sub_mod(o_p.y, p2_l.x);
          if (&eq_val) begin
            o_val <= 1'b1; // Every step written
            state <= S_DONE;
          end
        end
        S_DONE: begin
          if (i_rdy) begin
            o_val <= 1'b0;
            o_err <= 1'b0;
            o_rdy <= 1'b1;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Multiplier only answers steps that were issued and are still open
  a_rsp_tag: assert property (@(posedge i_clk) disable iff (i_rst)
    rsp_fire |-> eq_wait[i_rsp.tag] && !eq_val[i_rsp.tag]);

  // No multiply request left pending once the adder is idle
  a_no_idle_issue: assert property (@(posedge i_clk) disable iff (i_rst)
    (state == S_IDLE) |-> !o_mul_val);

endmodule

`default_nettype wire

// File: source/field_mult.sv
`default_nettype none

// Interleaved shift-and-add multiplier, b scanned from the MSB
module field_mult (
  input  wire logic              i_clk,
  input  wire logic              i_rst,
  input  wire ec_pkg::mult_req_t i_req,
  input  wire logic              i_req_val,
  output logic                   o_req_rdy,
  output ec_pkg::mult_rsp_t      o_rsp,
  output logic                   o_rsp_val,
  input  wire logic              i_rsp_rdy
);

  localparam logic [8:0] LAST = 9'(ec_pkg::MULT_CYCLES); // Count after final step

  logic            busy_q;   // Stepping through b
  logic [8:0]      cnt_q;    // Steps done so far
  ec_pkg::field_t  a_q;      // Multiplicand
  ec_pkg::field_t  b_q;      // Multiplier, shifted left each step
  ec_pkg::field_t  acc_q;    // Running product
  ec_pkg::eq_tag_t tag_q;
  ec_pkg::field_t  acc_dbl;  // 2*acc mod P
  ec_pkg::field_t  acc_nxt;
  logic            req_fire;

  // One item in flight, nothing accepted until the result has left
  assign o_req_rdy = !busy_q && !o_rsp_val;
  assign req_fire  = i_req_val && o_req_rdy;

  always_comb begin
    acc_dbl = ec_pkg::add_mod(acc_q, acc_q);
    acc_nxt = b_q[255] ? ec_pkg::add_mod(acc_dbl, a_q) : acc_dbl; // Add a on a set bit
  end

  // Control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      o_rsp_val <= 1'b0;
    end else begin
      if (req_fire) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        if (cnt_q == LAST) begin
          busy_q    <= 1'b0; // Extra cycle gives MULT_CYCLES + 1 latency
          o_rsp_val <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 9'd1;
        end
      end
      if (o_rsp_val && i_rsp_rdy) o_rsp_val <= 1'b0; // Product taken
    end
  end

  // Datapath, frozen while the response waits
  always_ff @(posedge i_clk) begin
    if (req_fire) begin
      a_q   <= i_req.a;
      b_q   <= i_req.b;
      tag_q <= i_req.tag;
      acc_q <= '0;
    end else if (busy_q && cnt_q != LAST) begin
      acc_q <= acc_nxt;
      b_q   <= {b_q[254:0], 1'b0}; // Next bit down
    end
  end

  assign o_rsp = '{prod: acc_q, tag: tag_q};

  // Response payload must not move under back-pressure
  a_rsp_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_rsp_val && !i_rsp_rdy |=> o_rsp_val && $stable(o_rsp));

endmodule

`default_nettype wire

// File: source/ec_pkg.sv
`default_nettype none

package ec_pkg;

  // One element of GF(p), always kept below P
  typedef logic [255:0] field_t;

  // Jacobian point, z == 0 stands for infinity
  typedef struct packed {
    field_t x;
    field_t y;
    field_t z;
  } jb_point_t;

  typedef logic [4:0] eq_tag_t; // Scoreboard step 0..23

  typedef struct packed {
    field_t  a;
    field_t  b;
    eq_tag_t tag; // Echoed back with the product
  } mult_req_t;

  typedef struct packed {
    field_t  prod; // a*b mod P
    eq_tag_t tag;
  } mult_rsp_t;

  // secp256k1 prime, 2^256 - 2^32 - 977
  localparam field_t P =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

  localparam int MULT_CYCLES = 256; // One bit of b per cycle

  // a + b mod P, both inputs below P so one subtract is enough
  function automatic field_t add_mod(input field_t a, input field_t b);
    logic [256:0] sum;
    logic [256:0] red;
    sum = {1'b0, a} + {1'b0, b};
    red = sum - {1'b0, P};
    return (sum >= {1'b0, P}) ? red[255:0] : sum[255:0];
  endfunction

  // a - b mod P, wraps back into range on borrow
  function automatic field_t sub_mod(input field_t a, input field_t b);
    return (a >= b) ? (a - b) : (a - b + P);
  endfunction

endpackage

`default_nettype wire
